// File: hw/ibuf_consts.svh
`ifndef IBUF_CONSTS_SVH
`define IBUF_CONSTS_SVH

// ========================================
// Line format
// ========================================
`define IBUF_LINE_W 64 // Fetch line bits
`define IBUF_LINE_HW 4 // Halfwords per line

// ========================================
// Queue and group sizes
// ========================================
`define IBUF_DEPTH 4
`define IBUF_DISP_SIZE 4

// Per-group category limits
`define IBUF_ARITH_LIMIT 2
`define IBUF_MEM_LIMIT 1
`define IBUF_BR_LIMIT 1
`define IBUF_ILL_LIMIT 1

`endif

// File: hw/ibuf_pkg.sv
`include "ibuf_consts.svh"

package ibuf_pkg;

  // ========================================
  // Vector types
  // ========================================
  typedef logic [`IBUF_LINE_W-1:0] line_t; // One aligned fetch line
  typedef logic [31:0] vaddr_t;
  typedef logic [31:0] inst_t; // RVC in [15:0], upper half zero

  // Halfword offset inside the head line
  typedef logic [$clog2(`IBUF_LINE_HW)-1:0] hw_off_t;

  // Halfwords consumed, 0 to two full lines
  typedef logic [$clog2(2 * `IBUF_LINE_HW):0] hw_cnt_t;

  typedef logic [`IBUF_DISP_SIZE-1:0] grp_mask_t; // One bit per slot

  // ========================================
  // Instruction category
  // ========================================
  typedef enum logic [1:0] {
    CAT_ARITH   = 2'd0,
    CAT_MEM     = 2'd1,
    CAT_BR      = 2'd2,
    CAT_ILLEGAL = 2'd3
  } inst_cat_t;

endpackage

// File: hw/ibuf_line_queue.sv
`timescale 1ns/1ps
`include "ibuf_consts.svh"

module ibuf_line_queue (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_flush,
  input  logic              i_line_valid,
  input  ibuf_pkg::vaddr_t  i_line_pc,
  input  ibuf_pkg::line_t   i_line_data,
  output logic              o_line_ready,
  input  logic              i_advance,
  input  ibuf_pkg::hw_cnt_t i_advance_hw,
  output logic              o_head_valid,
  output ibuf_pkg::line_t   o_head_data,
  output ibuf_pkg::vaddr_t  o_head_pc,
  output ibuf_pkg::hw_off_t o_head_off,
  output logic              o_next_valid,
  output ibuf_pkg::line_t   o_next_data
);

  localparam int PTR_W = $clog2(`IBUF_DEPTH);

  ibuf_pkg::line_t   r_data [`IBUF_DEPTH];
  ibuf_pkg::vaddr_t  r_pc [`IBUF_DEPTH];
  logic [`IBUF_DEPTH-1:0] r_valid;
  logic [PTR_W-1:0]  r_inptr;
  logic [PTR_W-1:0]  r_outptr;
  logic [PTR_W-1:0]  w_outptr_p1;
  logic [PTR_W-1:0]  w_outptr_p2;
  ibuf_pkg::hw_off_t r_head_off;
  ibuf_pkg::hw_cnt_t w_off_sum;
  logic              w_push;
  logic              w_pop1;
  logic              w_pop2;

  assign o_line_ready = ~&r_valid; // At least one free entry
  assign w_push       = i_line_valid & o_line_ready;

  assign w_outptr_p1 = r_outptr + PTR_W'(1);
  assign w_outptr_p2 = r_outptr + PTR_W'(2);

  // ========================================
  // Head position advance
  // ========================================
  assign w_off_sum = ibuf_pkg::hw_cnt_t'(r_head_off) + i_advance_hw;
  assign w_pop1    = i_advance & (w_off_sum >= ibuf_pkg::hw_cnt_t'(`IBUF_LINE_HW));
  assign w_pop2    = i_advance & (w_off_sum >= ibuf_pkg::hw_cnt_t'(2 * `IBUF_LINE_HW));

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid    <= '0;
      r_inptr    <= '0;
      r_outptr   <= '0;
      r_head_off <= '0;
    end else if (i_flush) begin
      r_valid    <= '0;
      r_inptr    <= '0;
      r_outptr   <= '0;
      r_head_off <= '0;
    end else begin
      // Push slot is always free, so never one of the popped entries
      if (w_push) begin
        r_valid[r_inptr] <= 1'b1;
        r_inptr          <= r_inptr + PTR_W'(1);
      end
      if (w_pop1) begin
        r_valid[r_outptr] <= 1'b0;
      end
      if (w_pop2) begin
        r_valid[w_outptr_p1] <= 1'b0;
      end
      if (w_pop2) begin
        r_outptr <= w_outptr_p2;
      end else if (w_pop1) begin
        r_outptr <= w_outptr_p1;
      end
      if (i_advance) begin
        r_head_off <= ibuf_pkg::hw_off_t'(w_off_sum); // Wraps into the new head
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_data[r_inptr] <= i_line_data;
      r_pc[r_inptr]   <= i_line_pc;
    end
  end

  assign o_head_valid = r_valid[r_outptr];
  assign o_head_data  = r_data[r_outptr];
  assign o_head_pc    = r_pc[r_outptr];
  assign o_head_off   = r_head_off;
  assign o_next_valid = r_valid[w_outptr_p1];
  assign o_next_data  = r_data[w_outptr_p1];

endmodule

// File: hw/ibuf_inst_extract.sv
`timescale 1ns/1ps
`include "ibuf_consts.svh"

module ibuf_inst_extract (
  input  logic                i_head_valid,
  input  logic                i_next_valid,
  input  ibuf_pkg::line_t     i_head_data,
  input  ibuf_pkg::line_t     i_next_data,
  input  ibuf_pkg::vaddr_t    i_head_pc,
  input  ibuf_pkg::hw_off_t   i_head_off,
  output ibuf_pkg::inst_t     o_slot_inst [`IBUF_DISP_SIZE],
  output ibuf_pkg::grp_mask_t o_slot_rvc,
  output ibuf_pkg::grp_mask_t o_slot_complete,
  output ibuf_pkg::grp_mask_t o_slot_len2,
  output ibuf_pkg::vaddr_t    o_slot_pc [`IBUF_DISP_SIZE]
);

  localparam int WIN_HW = 2 * `IBUF_LINE_HW; // Head plus next line
  localparam int IDX_W  = $clog2(WIN_HW);

  logic [15:0]       w_hw [WIN_HW];
  logic [WIN_HW-1:0] w_hw_vld;

  // ========================================
  // Halfword window
  // ========================================
  always_comb begin
    for (int h = 0; h < `IBUF_LINE_HW; h++) begin
      w_hw[h]                 = i_head_data[16*h +: 16];
      w_hw[h + `IBUF_LINE_HW] = i_next_data[16*h +: 16];
    end
  end

  assign w_hw_vld = {{`IBUF_LINE_HW{i_next_valid}}, {`IBUF_LINE_HW{i_head_valid}}};

  // ========================================
  // Boundary walk
  // ========================================
  always_comb begin
    ibuf_pkg::hw_cnt_t pos;
    ibuf_pkg::hw_cnt_t nxt;
    logic [15:0]       lo;
    logic [15:0]       hi;
    logic              lo_ok;
    logic              hi_ok;
    logic              rvc;
    pos = ibuf_pkg::hw_cnt_t'(i_head_off);
    for (int i = 0; i < `IBUF_DISP_SIZE; i++) begin
      nxt   = pos + ibuf_pkg::hw_cnt_t'(1);
      lo    = 16'h0;
      hi    = 16'h0;
      lo_ok = 1'b0;
      hi_ok = 1'b0;
      if (pos < ibuf_pkg::hw_cnt_t'(WIN_HW)) begin
        lo    = w_hw[pos[IDX_W-1:0]];
        lo_ok = w_hw_vld[pos[IDX_W-1:0]];
      end
      if (nxt < ibuf_pkg::hw_cnt_t'(WIN_HW)) begin
        hi    = w_hw[nxt[IDX_W-1:0]];
        hi_ok = w_hw_vld[nxt[IDX_W-1:0]];
      end
      rvc                = (lo[1:0] != 2'b11);
      o_slot_rvc[i]      = rvc;
      o_slot_len2[i]     = ~rvc;
      o_slot_inst[i]     = rvc ? {16'h0, lo} : {hi, lo}; // Upper half may sit in next line
      o_slot_complete[i] = rvc ? lo_ok : (lo_ok & hi_ok);
      o_slot_pc[i]       = i_head_pc + ibuf_pkg::vaddr_t'({pos, 1'b0});
      pos                = pos + (rvc ? ibuf_pkg::hw_cnt_t'(1) : ibuf_pkg::hw_cnt_t'(2));
    end
  end

endmodule

// File: hw/ibuf_inst_classify.sv
`timescale 1ns/1ps
`include "ibuf_consts.svh"

module ibuf_inst_classify (
  input  ibuf_pkg::inst_t     i_slot_inst [`IBUF_DISP_SIZE],
  input  ibuf_pkg::grp_mask_t i_slot_rvc,
  output ibuf_pkg::inst_cat_t o_slot_cat [`IBUF_DISP_SIZE]
);

  function automatic ibuf_pkg::inst_cat_t decode_cat(input ibuf_pkg::inst_t inst,
                                                     input logic rvc);
    ibuf_pkg::inst_cat_t cat;
    if (rvc) begin
      if (inst[15:0] == 16'h0) begin
        cat = ibuf_pkg::CAT_ILLEGAL; // Defined illegal halfword
      end else begin
        // Quadrant and funct3
        case ({inst[1:0], inst[15:13]})
          5'b00_010, 5'b00_110: cat = ibuf_pkg::CAT_MEM; // C.LW / C.SW
          5'b10_010, 5'b10_110: cat = ibuf_pkg::CAT_MEM; // Stack pointer forms
          5'b01_101, 5'b01_110, 5'b01_111: cat = ibuf_pkg::CAT_BR; // C.J, C.BEQZ, C.BNEZ
          default: cat = ibuf_pkg::CAT_ARITH;
        endcase
      end
    end else begin
      case (inst[6:0])
        7'b0010011, 7'b0110011, 7'b0110111,
        7'b0010111, 7'b0011011, 7'b0111011: cat = ibuf_pkg::CAT_ARITH;
        7'b0000011, 7'b0100011: cat = ibuf_pkg::CAT_MEM; // Load, store
        7'b1100011, 7'b1101111, 7'b1100111: cat = ibuf_pkg::CAT_BR;
        default: cat = ibuf_pkg::CAT_ILLEGAL;
      endcase
    end
    return cat;
  endfunction

  always_comb begin
    for (int i = 0; i < `IBUF_DISP_SIZE; i++) begin
      o_slot_cat[i] = decode_cat(i_slot_inst[i], i_slot_rvc[i]);
    end
  end

endmodule

// File: hw/ibuf_disp_select.sv
`timescale 1ns/1ps
`include "ibuf_consts.svh"

module ibuf_disp_select (
  input  logic                i_flush,
  input  ibuf_pkg::grp_mask_t i_slot_complete,
  input  ibuf_pkg::grp_mask_t i_slot_len2,
  input  ibuf_pkg::inst_cat_t i_slot_cat [`IBUF_DISP_SIZE],
  input  logic                i_disp_ready,
  output logic                o_disp_valid,
  output ibuf_pkg::grp_mask_t o_disp_slot_valid,
  output logic                o_advance,
  output ibuf_pkg::hw_cnt_t   o_advance_hw
);

  ibuf_pkg::grp_mask_t w_mask;
  ibuf_pkg::hw_cnt_t   w_mask_hw;

  // ========================================
  // Group formation
  // ========================================
  always_comb begin
    logic [2:0] cnt [4];
    logic [2:0] lim [4];
    logic       grp_open;
    logic       fits;
    lim[ibuf_pkg::CAT_ARITH]   = 3'(`IBUF_ARITH_LIMIT);
    lim[ibuf_pkg::CAT_MEM]     = 3'(`IBUF_MEM_LIMIT);
    lim[ibuf_pkg::CAT_BR]      = 3'(`IBUF_BR_LIMIT);
    lim[ibuf_pkg::CAT_ILLEGAL] = 3'(`IBUF_ILL_LIMIT);
    for (int c = 0; c < 4; c++) begin
      cnt[c] = 3'd0;
    end
    grp_open  = 1'b1;
    w_mask    = '0;
    w_mask_hw = '0;
    for (int i = 0; i < `IBUF_DISP_SIZE; i++) begin
      fits = (cnt[i_slot_cat[i]] < lim[i_slot_cat[i]]);
      if (grp_open && i_slot_complete[i] && fits) begin
        w_mask[i]           = 1'b1;
        cnt[i_slot_cat[i]]  = cnt[i_slot_cat[i]] + 3'd1;
        w_mask_hw           = w_mask_hw + (i_slot_len2[i] ? ibuf_pkg::hw_cnt_t'(2) :
                                                            ibuf_pkg::hw_cnt_t'(1));
        if (i_slot_cat[i] == ibuf_pkg::CAT_BR) begin
          grp_open = 1'b0; // Branch closes the group
        end
      end else begin
        grp_open = 1'b0; // Keep the mask a prefix
      end
    end
  end

  assign o_disp_slot_valid = i_flush ? '0 : w_mask;
  assign o_disp_valid      = (|w_mask) & ~i_flush;
  assign o_advance         = o_disp_valid & i_disp_ready; // Group consumed
  assign o_advance_hw      = w_mask_hw;

endmodule

// File: hw/ibuf_top.sv
`timescale 1ns/1ps
`include "ibuf_consts.svh"

module ibuf_top (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_flush,
  input  logic                i_line_valid,
  input  ibuf_pkg::vaddr_t    i_line_pc,
  input  ibuf_pkg::line_t     i_line_data,
  output logic                o_line_ready,
  input  logic                i_disp_ready,
  output logic                o_disp_valid,
  output ibuf_pkg::grp_mask_t o_disp_slot_valid,
  output ibuf_pkg::inst_t     o_disp_inst [`IBUF_DISP_SIZE],
  output ibuf_pkg::grp_mask_t o_disp_rvc,
  output ibuf_pkg::inst_cat_t o_disp_cat [`IBUF_DISP_SIZE],
  output ibuf_pkg::vaddr_t    o_disp_pc [`IBUF_DISP_SIZE]
);

  logic                w_head_valid;
  ibuf_pkg::line_t     w_head_data;
  ibuf_pkg::vaddr_t    w_head_pc;
  ibuf_pkg::hw_off_t   w_head_off;
  logic                w_next_valid;
  ibuf_pkg::line_t     w_next_data;
  logic                w_advance;
  ibuf_pkg::hw_cnt_t   w_advance_hw;
  ibuf_pkg::inst_t     w_slot_inst [`IBUF_DISP_SIZE];
  ibuf_pkg::grp_mask_t w_slot_rvc;
  ibuf_pkg::grp_mask_t w_slot_complete;
  ibuf_pkg::grp_mask_t w_slot_len2;
  ibuf_pkg::vaddr_t    w_slot_pc [`IBUF_DISP_SIZE];
  ibuf_pkg::inst_cat_t w_slot_cat [`IBUF_DISP_SIZE];

  ibuf_line_queue u_queue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_line_valid (i_line_valid),
    .i_line_pc    (i_line_pc),
    .i_line_data  (i_line_data),
    .o_line_ready (o_line_ready),
    .i_advance    (w_advance),
    .i_advance_hw (w_advance_hw),
    .o_head_valid (w_head_valid),
    .o_head_data  (w_head_data),
    .o_head_pc    (w_head_pc),
    .o_head_off   (w_head_off),
    .o_next_valid (w_next_valid),
    .o_next_data  (w_next_data)
  );

  ibuf_inst_extract u_extract (
    .i_head_valid    (w_head_valid),
    .i_next_valid    (w_next_valid),
    .i_head_data     (w_head_data),
    .i_next_data     (w_next_data),
    .i_head_pc       (w_head_pc),
    .i_head_off      (w_head_off),
    .o_slot_inst     (w_slot_inst),
    .o_slot_rvc      (w_slot_rvc),
    .o_slot_complete (w_slot_complete),
    .o_slot_len2     (w_slot_len2),
    .o_slot_pc       (w_slot_pc)
  );

  ibuf_inst_classify u_classify (
    .i_slot_inst (w_slot_inst),
    .i_slot_rvc  (w_slot_rvc),
    .o_slot_cat  (w_slot_cat)
  );

  ibuf_disp_select u_select (
    .i_flush           (i_flush),
    .i_slot_complete   (w_slot_complete),
    .i_slot_len2       (w_slot_len2),
    .i_slot_cat        (w_slot_cat),
    .i_disp_ready      (i_disp_ready),
    .o_disp_valid      (o_disp_valid),
    .o_disp_slot_valid (o_disp_slot_valid),
    .o_advance         (w_advance),
    .o_advance_hw      (w_advance_hw)
  );

  // Unselected slots read as zero
  assign o_disp_rvc = w_slot_rvc & o_disp_slot_valid;
  for (genvar g = 0; g < `IBUF_DISP_SIZE; g++) begin : g_disp
    assign o_disp_inst[g] = o_disp_slot_valid[g] ? w_slot_inst[g] : '0;
    assign o_disp_cat[g]  = o_disp_slot_valid[g] ? w_slot_cat[g] : ibuf_pkg::CAT_ARITH;
    assign o_disp_pc[g]   = o_disp_slot_valid[g] ? w_slot_pc[g] : '0;
  end

endmodule

// File: tests/ibuf_asserts.sv
`timescale 1ns/1ps

module ibuf_asserts (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic                i_flush,
  input logic                i_line_ready,
  input logic                i_disp_valid,
  input ibuf_pkg::grp_mask_t i_slot_valid
);

  // ========================================
  // Dispatch group shape
  // ========================================
  a_mask_prefix: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_slot_valid & (i_slot_valid + ibuf_pkg::grp_mask_t'(1))) == '0)
    else $error("slot mask is not a prefix");

  a_valid_mask: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid == (|i_slot_valid))
    else $error("dispatch valid does not match the slot mask");

  a_flush_quiet: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_flush |-> !i_disp_valid)
    else $error("dispatch valid high during flush");

  // Empty queue right out of reset
  a_ready_after_reset: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> i_line_ready)
    else $error("line input not ready after reset");

endmodule

bind ibuf_top ibuf_asserts u_asserts (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_flush      (i_flush),
  .i_line_ready (o_line_ready),
  .i_disp_valid (o_disp_valid),
  .i_slot_valid (o_disp_slot_valid)
);

// File: tests/tb_ibuf.sv
`timescale 1ns/1ps
`include "ibuf_consts.svh"

module tb_ibuf;

  localparam int TIMEOUT_CYCLES = 200;

  logic                i_clk = 1'b0;
  logic                i_reset_n;
  logic                i_flush;
  logic                i_line_valid;
  ibuf_pkg::vaddr_t    i_line_pc;
  ibuf_pkg::line_t     i_line_data;
  logic                o_line_ready;
  logic                i_disp_ready;
  logic                o_disp_valid;
  ibuf_pkg::grp_mask_t o_disp_slot_valid;
  ibuf_pkg::inst_t     o_disp_inst [`IBUF_DISP_SIZE];
  ibuf_pkg::grp_mask_t o_disp_rvc;
  ibuf_pkg::inst_cat_t o_disp_cat [`IBUF_DISP_SIZE];
  ibuf_pkg::vaddr_t    o_disp_pc [`IBUF_DISP_SIZE];

  logic [31:0] stim [512]; // Records from the data file
  logic [8:0]  rp;
  integer      seed = 32'hbc5c_1329;

  ibuf_top i_dut (.*);

  always #2 i_clk = ~i_clk;

  // ========================================
  // Helpers
  // ========================================
  task automatic stop_on_error();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  function automatic logic [31:0] take_word();
    logic [31:0] w;
    w  = stim[rp];
    rp = rp + 9'd1;
    return w;
  endfunction

  // ========================================
  // Record handlers, entered 1 ns after a rising edge
  // ========================================
  task automatic push_line();
    logic [31:0] pc;
    logic [31:0] hi;
    logic [31:0] lo;
    int          waited;
    bit          accepted;
    pc           = take_word();
    hi           = take_word();
    lo           = take_word();
    i_line_valid = 1'b1;
    i_line_pc    = pc;
    i_line_data  = {hi, lo};
    waited       = 0;
    accepted     = 1'b0;
    while (!accepted) begin
      #1;
      accepted = o_line_ready;
      @(posedge i_clk);
      #1;
      waited++;
      if (!accepted && waited > TIMEOUT_CYCLES) begin
        $display("Line input was never ready for the line at %h", pc);
        stop_on_error();
      end
    end
    i_line_valid = 1'b0;
  endtask

  task automatic flush_buffer();
    i_flush = 1'b1;
    @(posedge i_clk);
    #1;
    i_flush = 1'b0;
  endtask

  task automatic check_levels();
    logic [31:0] exp_ready;
    logic [31:0] exp_valid;
    exp_ready = take_word();
    exp_valid = take_word();
    #1;
    check_value("o_line_ready", 32'(o_line_ready), exp_ready);
    check_value("o_disp_valid", 32'(o_disp_valid), exp_valid);
    @(posedge i_clk);
    #1;
  endtask

  task automatic expect_group();
    int          n;
    logic [31:0] e_inst [`IBUF_DISP_SIZE];
    logic [31:0] e_rvc [`IBUF_DISP_SIZE];
    logic [31:0] e_cat [`IBUF_DISP_SIZE];
    logic [31:0] e_pc [`IBUF_DISP_SIZE];
    logic [3:0]  e_mask;
    logic [31:0] rnd;
    int          waited;
    bit          taken;
    n      = int'(take_word());
    e_mask = '0;
    for (int s = 0; s < `IBUF_DISP_SIZE; s++) begin
      e_inst[s] = '0; // Unused slots read as zero
      e_rvc[s]  = '0;
      e_cat[s]  = '0;
      e_pc[s]   = '0;
    end
    for (int s = 0; s < n; s++) begin
      e_inst[s] = take_word();
      e_rvc[s]  = take_word();
      e_cat[s]  = take_word();
      e_pc[s]   = take_word();
      e_mask[s] = 1'b1;
    end
    waited = 0;
    taken  = 1'b0;
    while (!taken) begin
      rnd          = $random(seed);
      i_disp_ready = (rnd[1:0] != 2'b00); // Stall about one cycle in four
      #1;
      if (o_disp_valid && i_disp_ready) begin
        taken = 1'b1;
        check_value("o_disp_slot_valid", 32'(o_disp_slot_valid), 32'(e_mask));
        for (int s = 0; s < `IBUF_DISP_SIZE; s++) begin
          check_value($sformatf("o_disp_inst[%0d]", s), o_disp_inst[s], e_inst[s]);
          check_value($sformatf("o_disp_rvc[%0d]", s), 32'(o_disp_rvc[s]), e_rvc[s]);
          check_value($sformatf("o_disp_cat[%0d]", s), 32'(o_disp_cat[s]), e_cat[s]);
          check_value($sformatf("o_disp_pc[%0d]", s), o_disp_pc[s], e_pc[s]);
        end
      end
      @(posedge i_clk);
      #1;
      i_disp_ready = 1'b0;
      waited++;
      if (!taken && waited > TIMEOUT_CYCLES) begin
        $display("No dispatch group appeared for the record ending at word %0d", rp);
        stop_on_error();
      end
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    logic [31:0] kind;
    bit          running;
    i_reset_n    = 1'b0;
    i_flush      = 1'b0;
    i_line_valid = 1'b0;
    i_line_pc    = '0;
    i_line_data  = '0;
    i_disp_ready = 1'b0;
    rp           = '0;
    $readmemh("tests/ibuf_tests.dat", stim);
    repeat (3) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    running   = 1'b1;
    while (running) begin
      kind = take_word();
      case (kind)
        32'd0: running = 1'b0;
        32'd1: push_line();
        32'd2: flush_buffer();
        32'd3: expect_group();
        32'd4: check_levels();
        default: begin
          $display("Unknown record kind %h in the test data", kind);
          stop_on_error();
        end
      endcase
    end
    $display("test passed");
    $finish;
  end

endmodule

// File: tests/ibuf_tests.dat
// Records of 32-bit hex words, one record per line
// 1 pc data_hi data_lo: push line | 2: flush | 4 ready valid: output levels | 0: end
// 3 n then n times {inst rvc cat pc}: expected group; cat 0 arith, 1 mem, 2 branch, 3 illegal
// Four 32-bit arithmetic instructions over two lines
1 00001000 00108133 00100093
1 00001008 00000217 123451B7
3 2 00100093 0 0 00001000 00108133 0 0 00001004
3 2 123451B7 0 0 00001008 00000217 0 0 0000100C
// Mixed lengths, the lw spans into the second line
1 00002000 A2830010 00930085
3 2 00000085 1 0 00002000 00100093 0 0 00002002
4 1 0
1 00002008 0001A001 41880000
3 1 0000A283 0 1 00002006
3 2 00004188 1 1 0000200A 0000A001 1 2 0000200C
3 1 00000001 1 0 0000200E
// Categories and limits, with the queue filled
1 00003000 0000852E C006C188
1 00003008 0050A223 00000063
1 00003010 0000007F 4082C001
1 00003018 0085E001 000000EF
4 0 1
3 1 0000C188 1 1 00003000
3 4 0000C006 1 1 00003002 0000852E 1 0 00003004 00000000 1 3 00003006 00000063 0 2 00003008
1 00003020 00108133 00100093
3 2 0050A223 0 1 0000300C 0000C001 1 2 00003010
3 3 00004082 1 1 00003012 0000007F 0 3 00003014 000000EF 0 2 00003018
3 1 0000E001 1 2 0000301C
3 2 00000085 1 0 0000301E 00100093 0 0 00003020
3 1 00108133 0 0 00003024
// Flush with a partly consumed head line
1 00004000 00850085 00850085
3 2 00000085 1 0 00004000 00000085 1 0 00004002
1 00004008 00108133 00100093
2
4 1 0
1 00005000 0000A283 41880001
3 2 00000001 1 0 00005000 00004188 1 1 00005002
3 1 0000A283 0 1 00005004
4 1 0
0

// File: sim.f
+incdir+hw
hw/ibuf_pkg.sv
hw/ibuf_line_queue.sv
hw/ibuf_inst_extract.sv
hw/ibuf_inst_classify.sv
hw/ibuf_disp_select.sv
hw/ibuf_top.sv
tests/ibuf_asserts.sv
tests/tb_ibuf.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the instruction buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"
verilator --binary --timing --assert -f sim.f --top-module tb_ibuf -Mdir obj_dir -o tb_ibuf \
  && { ./obj_dir/tb_ibuf > "$log" 2>&1 || true; } \
  && cat "$log" \
  && ! grep -q "test failed" "$log" \
  && grep -q "test passed" "$log" \
  || { echo "Simulation FAILED, see $log"; exit 1; }
echo "Simulation PASSED"
